/* design/mmu_pkg.sv */
//####################################################################
// MMU package
// Address widths and MMU-wide enumerations shared by the TLB levels
//####################################################################

package mmu_pkg;

  // Sv32-like widths
  localparam int VPN_LEN  = 20;
  localparam int PPN_LEN  = 20;
  localparam int ASID_LEN = 8;

  typedef logic [VPN_LEN-1:0]  vpn_t;
  typedef logic [PPN_LEN-1:0]  ppn_t;
  typedef logic [ASID_LEN-1:0] asid_t;

  // Only the full flush is supported
  typedef enum logic {
    FlushNone,
    FlushAll
  } tlb_flush_e;

  typedef enum logic [1:0] {
    NoException,
    PageFault
  } exception_e;

  // Which L1 TLB issued the request and gets the answer
  typedef enum logic {
    ITLB,
    DTLB
  } tlb_dest_e;

endpackage

/* design/l2tlb_pkg.sv */
//####################################################################
// L2 TLB package
// Channel structs, stored entry layout and way memory controls
//####################################################################

package l2tlb_pkg;

  import mmu_pkg::*;

  // L1 TLB -> L2 TLB lookup request
  typedef struct packed {
    logic      valid;
    vpn_t      vpn;
    tlb_dest_e origin;
  } l1_req_t;

  // Walker -> L2 TLB answer
  typedef struct packed {
    logic       valid;
    ppn_t       ppn;
    exception_e exception;
    logic       glob;
  } ptw_ans_t;

  // L2 TLB -> walker request
  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } ptw_req_t;

  // L2 TLB -> L1 TLBs answer
  typedef struct packed {
    logic       valid;
    logic       hit;
    ppn_t       ppn;
    exception_e exception;
    tlb_dest_e  destination;
  } l2_ans_t;

  // Stored entry, valid sits in bit 0 of the low byte
  typedef struct packed {
    logic  glob;
    asid_t asid;
    ppn_t  ppn;
    vpn_t  vpn;
    logic  valid;
  } tlb_entry_t;

  localparam int ENTRY_BYTES = ($bits(tlb_entry_t) + 7) / 8;

  // Per-way memory control, one byte enable per entry byte
  typedef struct packed {
    logic                   cs;
    logic                   we;
    logic [ENTRY_BYTES-1:0] be;
  } mem_ctrl_t;

  typedef enum logic [1:0] {
    Idle,
    Read,
    PtwAns
  } t0_t1_type_e;

  typedef struct packed {
    t0_t1_type_e req_type;
    vpn_t        vpn;
    tlb_dest_e   destination;
    ppn_t        ppn;
    exception_e  exception;
    logic        glob;
  } t0_t1_req_t;

  typedef enum logic {
    NoReq,
    ReplaceLine
  } t1_t0_type_e;

  typedef struct packed {
    logic        valid;
    t1_t0_type_e req_type;
    vpn_t        vpn;
    ppn_t        ppn;
    logic        glob;
  } t1_t0_req_t;

endpackage

/* design/l2tlb_way_mem.sv */
//####################################################################
// L2 TLB way memory
// One way of entries, registered read, byte-enabled write
//####################################################################

`timescale 1ns/1ns

module l2tlb_way_mem #(
  parameter int IDX_LEN = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  l2tlb_pkg::mem_ctrl_t  ctrl_i,
  input  logic [IDX_LEN-1:0]    addr_i,
  input  l2tlb_pkg::tlb_entry_t wentry_i,
  output l2tlb_pkg::tlb_entry_t rentry_o
);

  import l2tlb_pkg::*;

  localparam int DEPTH = 2**IDX_LEN;
  localparam int W     = $bits(tlb_entry_t);

  logic [W-1:0]     mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  logic [W-1:0]     wmask;
  tlb_entry_t       rdata_q;
  logic             rvalid_q;

  // Expand byte enables to a bit mask
  always_comb begin
    for (int i = 0; i < W; i++) begin
      wmask[i] = ctrl_i.be[i/8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.cs && ctrl_i.we) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask) | (wentry_i & wmask);
    end
    if (ctrl_i.cs && !ctrl_i.we) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  // Valid bits live apart so they clear on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= '0;
      rvalid_q <= 1'b0;
    end else if (ctrl_i.cs) begin
      if (ctrl_i.we && ctrl_i.be[0]) begin
        valid_q[addr_i] <= wentry_i.valid;
      end
      if (!ctrl_i.we) begin
        rvalid_q <= valid_q[addr_i];
      end
    end
  end

  always_comb begin
    rentry_o       = rdata_q;
    rentry_o.valid = rvalid_q;
  end

endmodule

/* design/l2tlb_sched.sv */
//####################################################################
// L2 TLB t0 stage
// Fixed-priority scheduler in front of the way memories, memory
// controller, ready signals and t0 -> t1 data selection
//####################################################################

`timescale 1ns/1ns

module l2tlb_sched #(
  parameter int IDX_LEN = 2,
  parameter int N_WAY   = 2
) (
  input  mmu_pkg::asid_t         base_asid_i,
  // Flush controller channel
  input  logic                   flush_req_valid_i,
  input  logic [IDX_LEN-1:0]     flush_idx_i,
  output logic                   flush_idx_cnt_en_o,
  // L1 TLB request
  input  l2tlb_pkg::l1_req_t     l1_req_i,
  output logic                   l1_rdy_o,
  // Walker answer
  input  l2tlb_pkg::ptw_ans_t    ptw_ans_i,
  output logic                   ptw_rdy_o,
  // Way memories
  output l2tlb_pkg::mem_ctrl_t   mem_ctrl_o [N_WAY],
  output logic [IDX_LEN-1:0]     mem_addr_o,
  output l2tlb_pkg::tlb_entry_t  mem_wentry_o,
  // t0 -> t1 registers
  output l2tlb_pkg::t0_t1_req_t  t0_t1_req_o,
  output logic                   t0_t1_en_o,
  // t1 -> t0 refill request
  input  l2tlb_pkg::t1_t0_req_t  t1_t0_req_i,
  // MSHR
  input  logic                   mshr_full_i,
  output logic                   rm_mshr_o,
  // Replacement way, one-hot
  input  logic [N_WAY-1:0]       repl_vec_i
);

  import mmu_pkg::*;
  import l2tlb_pkg::*;

  typedef enum logic [2:0] {
    WinNone,
    WinL1,
    WinPtw,
    WinFlush,
    WinT1
  } winner_e;

  // Byte enable touching only the valid byte
  localparam logic [ENTRY_BYTES-1:0] BE_VALID = ENTRY_BYTES'(1);

  winner_e winner;

  // Descending priority: refill, flush, walker, L1
  always_comb begin
    winner = WinNone;
    if (t1_t0_req_i.valid && t1_t0_req_i.req_type == ReplaceLine) begin
      winner = WinT1;
    end else if (flush_req_valid_i) begin
      winner = WinFlush;
    end else if (ptw_ans_i.valid) begin
      winner = WinPtw;
    end else if (l1_req_i.valid && !mshr_full_i) begin
      // New lookups wait while a miss is outstanding
      winner = WinL1;
    end
  end

  assign l1_rdy_o           = (winner == WinL1);
  assign ptw_rdy_o          = (winner == WinPtw);
  assign flush_idx_cnt_en_o = (winner == WinFlush);
  // Only lookups and walker answers have work for t1
  assign t0_t1_en_o         = (winner == WinL1) || (winner == WinPtw);
  // Faulting answers never refill, so they free the MSHR at once
  assign rm_mshr_o          = (winner == WinT1) ||
                              (winner == WinPtw && ptw_ans_i.exception != NoException);

  always_comb begin
    mem_addr_o = '0;
    for (int k = 0; k < N_WAY; k++) begin
      mem_ctrl_o[k] = '0;
    end
    case (winner)
      WinL1: begin
        mem_addr_o = l1_req_i.vpn[IDX_LEN-1:0];
        for (int k = 0; k < N_WAY; k++) begin
          mem_ctrl_o[k].cs = 1'b1;
          mem_ctrl_o[k].be = '1;
        end
      end
      WinPtw: begin
        // Set of the pending miss, held by t1
        mem_addr_o = t1_t0_req_i.vpn[IDX_LEN-1:0];
        if (ptw_ans_i.exception == NoException) begin
          for (int k = 0; k < N_WAY; k++) begin
            mem_ctrl_o[k].cs = 1'b1;
            mem_ctrl_o[k].be = '1;
          end
        end
      end
      WinFlush: begin
        // Clear the valid bit of every way in one go
        mem_addr_o = flush_idx_i;
        for (int k = 0; k < N_WAY; k++) begin
          mem_ctrl_o[k].cs = 1'b1;
          mem_ctrl_o[k].we = 1'b1;
          mem_ctrl_o[k].be = BE_VALID;
        end
      end
      WinT1: begin
        // Full write into the victim way only
        mem_addr_o = t1_t0_req_i.vpn[IDX_LEN-1:0];
        for (int k = 0; k < N_WAY; k++) begin
          mem_ctrl_o[k].cs = repl_vec_i[k];
          mem_ctrl_o[k].we = repl_vec_i[k];
          mem_ctrl_o[k].be = '1;
        end
      end
      default: begin
      end
    endcase
  end

  // Write entry, valid only for a refill
  always_comb begin
    mem_wentry_o.valid = (winner == WinT1);
    mem_wentry_o.vpn   = t1_t0_req_i.vpn;
    mem_wentry_o.ppn   = t1_t0_req_i.ppn;
    mem_wentry_o.asid  = base_asid_i;
    mem_wentry_o.glob  = t1_t0_req_i.glob;
  end

  // t0 -> t1 payload
  always_comb begin
    case (winner)
      WinL1:   t0_t1_req_o.req_type = Read;
      WinPtw:  t0_t1_req_o.req_type = PtwAns;
      default: t0_t1_req_o.req_type = Idle;
    endcase
    t0_t1_req_o.vpn         = l1_req_i.vpn;
    t0_t1_req_o.destination = l1_req_i.origin;
    t0_t1_req_o.ppn         = ptw_ans_i.ppn;
    t0_t1_req_o.exception   = ptw_ans_i.exception;
    t0_t1_req_o.glob        = ptw_ans_i.glob;
  end

endmodule

/* design/l2tlb_lookup.sv */
//####################################################################
// L2 TLB t1 stage
// Tag compare, answer to the L1 TLBs, miss and refill sequencing,
// round-robin victim selection per set
//####################################################################

`timescale 1ns/1ns

module l2tlb_lookup #(
  parameter int IDX_LEN = 2,
  parameter int N_WAY   = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  l2tlb_pkg::t0_t1_req_t t0_t1_req_i,
  input  logic                  t0_t1_en_i,
  input  l2tlb_pkg::tlb_entry_t rentry_i [N_WAY],
  input  mmu_pkg::asid_t        base_asid_i,
  output l2tlb_pkg::l2_ans_t    l2_ans_o,
  output l2tlb_pkg::t1_t0_req_t t1_t0_req_o,
  output logic [N_WAY-1:0]      repl_vec_o,
  // MSHR fill and pending destination
  output logic                  mshr_fill_o,
  output mmu_pkg::vpn_t         mshr_vpn_o,
  output mmu_pkg::tlb_dest_e    mshr_dest_o,
  input  mmu_pkg::tlb_dest_e    mshr_dest_i
);

  import mmu_pkg::*;
  import l2tlb_pkg::*;

  localparam int N_SET   = 2**IDX_LEN;
  localparam int PTR_LEN = (N_WAY > 1) ? $clog2(N_WAY) : 1;

  t0_t1_type_e        type_q;
  vpn_t               vpn_q;
  tlb_dest_e          dest_q;
  ppn_t               ppn_q;
  exception_e         exc_q;
  logic               glob_q;
  logic               repl_q;
  logic [PTR_LEN-1:0] rr_q [N_SET];
  logic [IDX_LEN-1:0] set_idx;
  logic [N_WAY-1:0]   hit_vec;
  logic               hit;
  ppn_t               hit_ppn;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      type_q <= Idle;
      repl_q <= 1'b0;
      rr_q   <= '{default: '0};
    end else begin
      // One cycle per scheduled request
      type_q <= t0_t1_en_i ? t0_t1_req_i.req_type : Idle;
      // Refill goes out the cycle after the walker answer
      repl_q <= (type_q == PtwAns) && (exc_q == NoException);
      if (repl_q) begin
        rr_q[set_idx] <= (rr_q[set_idx] == PTR_LEN'(N_WAY-1)) ? '0 : rr_q[set_idx] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (t0_t1_en_i) begin
      ppn_q  <= t0_t1_req_i.ppn;
      exc_q  <= t0_t1_req_i.exception;
      glob_q <= t0_t1_req_i.glob;
      // Missing VPN stays here until the refill
      if (t0_t1_req_i.req_type == Read) begin
        vpn_q  <= t0_t1_req_i.vpn;
        dest_q <= t0_t1_req_i.destination;
      end
    end
  end

  assign set_idx = vpn_q[IDX_LEN-1:0];

  // Valid, same VPN, and global or same ASID
  always_comb begin
    hit_ppn = '0;
    for (int w = 0; w < N_WAY; w++) begin
      hit_vec[w] = rentry_i[w].valid && (rentry_i[w].vpn == vpn_q) &&
                   (rentry_i[w].glob || rentry_i[w].asid == base_asid_i);
      if (hit_vec[w]) begin
        hit_ppn = rentry_i[w].ppn;
      end
    end
  end

  assign hit = |hit_vec;

  always_comb begin
    l2_ans_o.valid       = 1'b0;
    l2_ans_o.hit         = 1'b0;
    l2_ans_o.ppn         = hit_ppn;
    l2_ans_o.exception   = NoException;
    l2_ans_o.destination = dest_q;
    if (type_q == Read && hit) begin
      l2_ans_o.valid = 1'b1;
      l2_ans_o.hit   = 1'b1;
    end else if (type_q == PtwAns) begin
      // Walker result forwarded to the requester held in the MSHR
      l2_ans_o.valid       = 1'b1;
      l2_ans_o.ppn         = ppn_q;
      l2_ans_o.exception   = exc_q;
      l2_ans_o.destination = mshr_dest_i;
    end
  end

  // Miss parks the request
  assign mshr_fill_o = (type_q == Read) && !hit;
  assign mshr_vpn_o  = vpn_q;
  assign mshr_dest_o = dest_q;

  // Refill request, payload held since the miss
  always_comb begin
    t1_t0_req_o.valid    = repl_q;
    t1_t0_req_o.req_type = repl_q ? ReplaceLine : NoReq;
    t1_t0_req_o.vpn      = vpn_q;
    t1_t0_req_o.ppn      = ppn_q;
    t1_t0_req_o.glob     = glob_q;
  end

  // Victim way of the current set
  always_comb begin
    repl_vec_o               = '0;
    repl_vec_o[rr_q[set_idx]] = 1'b1;
  end

endmodule

/* design/l2tlb_mshr.sv */
//####################################################################
// L2 TLB miss holding register
// One outstanding miss, issues the walker request
//####################################################################

`timescale 1ns/1ns

module l2tlb_mshr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fill_i,
  input  mmu_pkg::vpn_t      vpn_i,
  input  mmu_pkg::tlb_dest_e dest_i,
  input  logic               rm_i,
  output logic               full_o,
  output mmu_pkg::vpn_t      vpn_o,
  output mmu_pkg::tlb_dest_e dest_o,
  output logic               ptw_req_o
);

  import mmu_pkg::*;

  logic      full_q;
  vpn_t      vpn_q;
  tlb_dest_e dest_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (fill_i) begin
      full_q <= 1'b1;
    end else if (rm_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload survives removal, t1 reads it one cycle later
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      vpn_q  <= vpn_i;
      dest_q <= dest_i;
    end
  end

  assign full_o    = full_q;
  // Walker sees the VPN in the fill cycle already
  assign vpn_o     = full_q ? vpn_q : vpn_i;
  assign dest_o    = dest_q;
  assign ptw_req_o = fill_i;

endmodule

/* design/l2tlb_flush_ctrl.sv */
//####################################################################
// L2 TLB flush controller
// Walks every set for a full flush and reports the end
//####################################################################

`timescale 1ns/1ns

module l2tlb_flush_ctrl #(
  parameter int IDX_LEN = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               cnt_en_i,
  output logic               req_valid_o,
  output logic [IDX_LEN-1:0] idx_o,
  output logic               done_o
);

  import mmu_pkg::*;

  tlb_flush_e         state_q;
  logic [IDX_LEN-1:0] idx_q;
  logic               done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FlushNone;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == FlushNone) begin
        if (flush_i) begin
          state_q <= FlushAll;
          idx_q   <= '0;
        end
      end else if (cnt_en_i) begin
        // Scheduler may stall us behind a refill
        idx_q <= idx_q + 1'b1;
        if (idx_q == '1) begin
          state_q <= FlushNone;
          done_q  <= 1'b1;
        end
      end
    end
  end

  assign req_valid_o = (state_q == FlushAll);
  assign idx_o       = idx_q;
  assign done_o      = done_q;

endmodule

/* design/l2tlb_top.sv */
//####################################################################
// L2 TLB top level
// Scheduler, way memories, lookup stage, MSHR and flush controller
//####################################################################

`timescale 1ns/1ns

module l2tlb_top #(
  parameter int IDX_LEN = 2,
  parameter int N_WAY   = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  mmu_pkg::asid_t      base_asid_i,
  input  logic                flush_i,
  output logic                flush_done_o,
  input  l2tlb_pkg::l1_req_t  l1_req_i,
  output logic                l1_rdy_o,
  input  l2tlb_pkg::ptw_ans_t ptw_ans_i,
  output logic                ptw_rdy_o,
  output l2tlb_pkg::ptw_req_t ptw_req_o,
  output l2tlb_pkg::l2_ans_t  l2_ans_o
);

  import mmu_pkg::*;
  import l2tlb_pkg::*;

  logic               flush_req_valid;
  logic [IDX_LEN-1:0] flush_idx;
  logic               flush_cnt_en;
  mem_ctrl_t          mem_ctrl [N_WAY];
  logic [IDX_LEN-1:0] mem_addr;
  tlb_entry_t         mem_wentry;
  tlb_entry_t         rentry [N_WAY];
  t0_t1_req_t         t0_t1_req;
  logic               t0_t1_en;
  t1_t0_req_t         t1_t0_req;
  logic [N_WAY-1:0]   repl_vec;
  logic               mshr_full;
  logic               rm_mshr;
  logic               mshr_fill;
  vpn_t               mshr_fill_vpn;
  tlb_dest_e          mshr_fill_dest;
  tlb_dest_e          mshr_dest;
  vpn_t               mshr_vpn;
  logic               ptw_req_valid;

  l2tlb_sched #(.IDX_LEN(IDX_LEN), .N_WAY(N_WAY)) u_sched (
    .base_asid_i        (base_asid_i),
    .flush_req_valid_i  (flush_req_valid),
    .flush_idx_i        (flush_idx),
    .flush_idx_cnt_en_o (flush_cnt_en),
    .l1_req_i           (l1_req_i),
    .l1_rdy_o           (l1_rdy_o),
    .ptw_ans_i          (ptw_ans_i),
    .ptw_rdy_o          (ptw_rdy_o),
    .mem_ctrl_o         (mem_ctrl),
    .mem_addr_o         (mem_addr),
    .mem_wentry_o       (mem_wentry),
    .t0_t1_req_o        (t0_t1_req),
    .t0_t1_en_o         (t0_t1_en),
    .t1_t0_req_i        (t1_t0_req),
    .mshr_full_i        (mshr_full),
    .rm_mshr_o          (rm_mshr),
    .repl_vec_i         (repl_vec)
  );

  // One memory per way, shared address and write data
  for (genvar w = 0; w < N_WAY; w++) begin : g_way
    l2tlb_way_mem #(.IDX_LEN(IDX_LEN)) u_way (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .ctrl_i   (mem_ctrl[w]),
      .addr_i   (mem_addr),
      .wentry_i (mem_wentry),
      .rentry_o (rentry[w])
    );
  end

  l2tlb_lookup #(.IDX_LEN(IDX_LEN), .N_WAY(N_WAY)) u_lookup (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .t0_t1_req_i (t0_t1_req),
    .t0_t1_en_i  (t0_t1_en),
    .rentry_i    (rentry),
    .base_asid_i (base_asid_i),
    .l2_ans_o    (l2_ans_o),
    .t1_t0_req_o (t1_t0_req),
    .repl_vec_o  (repl_vec),
    .mshr_fill_o (mshr_fill),
    .mshr_vpn_o  (mshr_fill_vpn),
    .mshr_dest_o (mshr_fill_dest),
    .mshr_dest_i (mshr_dest)
  );

  l2tlb_mshr u_mshr (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .fill_i    (mshr_fill),
    .vpn_i     (mshr_fill_vpn),
    .dest_i    (mshr_fill_dest),
    .rm_i      (rm_mshr),
    .full_o    (mshr_full),
    .vpn_o     (mshr_vpn),
    .dest_o    (mshr_dest),
    .ptw_req_o (ptw_req_valid)
  );

  l2tlb_flush_ctrl #(.IDX_LEN(IDX_LEN)) u_flush_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .cnt_en_i    (flush_cnt_en),
    .req_valid_o (flush_req_valid),
    .idx_o       (flush_idx),
    .done_o      (flush_done_o)
  );

  // Walker request pulse with the missing VPN
  assign ptw_req_o.valid = ptw_req_valid;
  assign ptw_req_o.vpn   = mshr_vpn;

endmodule

/* test/l2tlb_assert.sv */
//####################################################################
// L2 TLB protocol assertions
// Answer origin, walker request VPN and MSHR rules at the top level
//####################################################################

`timescale 1ns/1ns

module l2tlb_assert (
  input logic                clk_i,
  input logic                rst_n_i,
  input l2tlb_pkg::l1_req_t  l1_req_i,
  input logic                l1_rdy_i,
  input l2tlb_pkg::ptw_ans_t ptw_ans_i,
  input logic                ptw_rdy_i,
  input l2tlb_pkg::ptw_req_t ptw_req_i,
  input l2tlb_pkg::l2_ans_t  l2_ans_i,
  input logic                mshr_full_i
);

  int unsigned fail_cnt = 0;

  // Every answer follows a handshake one cycle earlier
  ans_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l2_ans_i.valid |-> ($past(l1_req_i.valid && l1_rdy_i) ||
                        $past(ptw_ans_i.valid && ptw_rdy_i)))
  else begin
    $error("l2_ans_o.valid without an accepted request");
    fail_cnt++;
  end

  // Single MSHR, no second walk
  ptw_req_mshr_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ptw_req_i.valid |-> !mshr_full_i)
  else begin
    $error("ptw_req_o pulsed while the MSHR was full");
    fail_cnt++;
  end

  // Walker request carries the VPN of the lookup accepted one cycle earlier
  ptw_req_vpn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ptw_req_i.valid |-> ($past(l1_req_i.valid && l1_rdy_i) &&
                         (ptw_req_i.vpn == $past(l1_req_i.vpn))))
  else begin
    $error("ptw_req_o without the VPN of the lookup accepted before it");
    fail_cnt++;
  end

endmodule

bind l2tlb_top l2tlb_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .l1_req_i    (l1_req_i),
  .l1_rdy_i    (l1_rdy_o),
  .ptw_ans_i   (ptw_ans_i),
  .ptw_rdy_i   (ptw_rdy_o),
  .ptw_req_i   (ptw_req_o),
  .l2_ans_i    (l2_ans_o),
  .mshr_full_i (mshr_full)
);

/* test/l2tlb_tb.sv */
//####################################################################
// L2 TLB testbench
// Script-driven lookups, walker model and flushes with checked answers
//####################################################################

`timescale 1ns/1ns

module l2tlb_tb;

  import mmu_pkg::*;
  import l2tlb_pkg::*;

  localparam int IDX_LEN   = 2;
  localparam int N_WAY     = 2;
  // Cycles any single wait may take
  localparam int TIMEOUT   = 50;
  // Cycles the walker stays busy before it answers
  localparam int PTW_DELAY = 2;

  logic     clk;
  logic     rst_n;
  asid_t    base_asid;
  logic     flush;
  logic     flush_done;
  l1_req_t  l1_req;
  logic     l1_rdy;
  ptw_ans_t ptw_ans;
  logic     ptw_rdy;
  ptw_req_t ptw_req;
  l2_ans_t  l2_ans;

  int            fd;
  int            n;
  int            lookup_cnt;
  logic          script_end;
  logic [63:0]   op;
  logic [31:0]   f0;
  logic [31:0]   f1;
  logic [31:0]   f2;
  logic [31:0]   f3;
  logic [1023:0] line_buf;

  l2tlb_top #(.IDX_LEN(IDX_LEN), .N_WAY(N_WAY)) dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .base_asid_i  (base_asid),
    .flush_i      (flush),
    .flush_done_o (flush_done),
    .l1_req_i     (l1_req),
    .l1_rdy_o     (l1_rdy),
    .ptw_ans_i    (ptw_ans),
    .ptw_rdy_o    (ptw_rdy),
    .ptw_req_o    (ptw_req),
    .l2_ans_o     (l2_ans)
  );

  always #50 clk = ~clk;

  task automatic end_in_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      end_in_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
    end_in_failure();
  endtask

  // Walker model, answers the pending miss with the next reply line
  task automatic serve_walker(input logic [31:0] vpn, input logic [31:0] exp_ppn,
                              input logic [31:0] exp_exc, input logic dest);
    logic [63:0] tag;
    logic [31:0] w_ppn;
    logic [31:0] w_glob;
    logic [31:0] w_exc;
    int          cnt;
    int          i;
    int          n_fields;
    tag = '0;
    n_fields = $fscanf(fd, "%s %h %h %h", tag, w_ppn, w_glob, w_exc);
    if (n_fields != 4 || tag != "W") begin
      $display("Golden file has no walker reply for VPN %0h", vpn);
      end_in_failure();
    end
    // Walker busy, a second lookup must be held off
    for (i = 0; i < PTW_DELAY; i++) begin
      @(negedge clk);
      l1_req.valid = 1'b1;
      l1_req.vpn   = vpn_t'(vpn ^ 32'h100);
      #1;
      check_value(32'(l1_rdy), 32'd0, "l1_rdy_o while MSHR is full");
    end
    @(negedge clk);
    l1_req.valid      = 1'b0;
    ptw_ans.valid     = 1'b1;
    ptw_ans.ppn       = ppn_t'(w_ppn);
    ptw_ans.glob      = w_glob[0];
    ptw_ans.exception = exception_e'(w_exc[1:0]);
    #1;
    cnt = 0;
    while (!ptw_rdy) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        report_timeout("ptw_rdy_o");
      end
      @(negedge clk);
      #1;
    end
    // Answer goes out the cycle after acceptance
    @(negedge clk);
    ptw_ans.valid = 1'b0;
    #1;
    check_value(32'(l2_ans.valid), 32'd1, "walker answer valid");
    check_value(32'(l2_ans.hit), 32'd0, "walker answer hit flag");
    check_value(32'(l2_ans.ppn), exp_ppn, "walker answer ppn");
    check_value(32'(l2_ans.exception), exp_exc, "walker answer exception");
    check_value(32'(l2_ans.destination), 32'(dest), "walker answer destination");
  endtask

  task automatic lookup_and_check(input logic [31:0] vpn, input logic [31:0] exp_hit,
                                  input logic [31:0] exp_ppn, input logic [31:0] exp_exc);
    logic dest;
    int   cnt;
    // Alternate between ITLB and DTLB requesters
    dest = lookup_cnt[0];
    lookup_cnt++;
    @(negedge clk);
    l1_req.valid  = 1'b1;
    l1_req.vpn    = vpn_t'(vpn);
    l1_req.origin = tlb_dest_e'(dest);
    #1;
    cnt = 0;
    while (!l1_rdy) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        report_timeout("l1_rdy_o");
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    l1_req.valid = 1'b0;
    #1;
    check_value(32'(ptw_req.valid), 32'(exp_hit == 0), "walker request after lookup");
    if (exp_hit != 0) begin
      check_value(32'(l2_ans.valid), 32'd1, "hit answer valid");
      check_value(32'(l2_ans.hit), 32'd1, "hit flag");
      check_value(32'(l2_ans.ppn), exp_ppn, "hit ppn");
      check_value(32'(l2_ans.exception), exp_exc, "hit exception");
      check_value(32'(l2_ans.destination), 32'(dest), "hit destination");
    end else begin
      // Miss stays silent until the walker answers
      check_value(32'(l2_ans.valid), 32'd0, "answer in miss cycle");
      check_value(32'(ptw_req.vpn), vpn, "walker request VPN");
      serve_walker(vpn, exp_ppn, exp_exc, dest);
    end
  endtask

  task automatic flush_all();
    int cnt;
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #1;
    cnt = 0;
    while (!flush_done) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        report_timeout("flush_done_o");
      end
      @(negedge clk);
      #1;
    end
  endtask

  task automatic change_asid(input logic [31:0] asid);
    // A pending refill still writes with the old ASID
    repeat (2) @(negedge clk);
    base_asid = asid_t'(asid);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    base_asid  = '0;
    flush      = 1'b0;
    l1_req     = '0;
    ptw_ans    = '0;
    lookup_cnt = 0;
    script_end = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value(32'(l1_rdy), 32'd0, "l1_rdy_o after reset");
    check_value(32'(ptw_rdy), 32'd0, "ptw_rdy_o after reset");
    check_value(32'(ptw_req.valid), 32'd0, "ptw_req_o after reset");
    check_value(32'(l2_ans.valid), 32'd0, "l2_ans_o after reset");
    check_value(32'(flush_done), 32'd0, "flush_done_o after reset");

    fd = $fopen("test/l2tlb_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file test/l2tlb_golden.txt");
      end_in_failure();
    end
    while (!script_end && !$feof(fd)) begin
      op = '0;
      n = $fscanf(fd, "%s", op);
      if (n != 1) begin
        script_end = 1'b1;
      end else if (op == "#") begin
        void'($fgets(line_buf, fd));
      end else if (op == "A") begin
        n = $fscanf(fd, "%h", f0);
        if (n != 1) begin
          $display("ASID line in the golden file lacks its value");
          end_in_failure();
        end
        change_asid(f0);
      end else if (op == "L") begin
        n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
        if (n != 4) begin
          $display("Lookup line in the golden file lacks fields");
          end_in_failure();
        end
        lookup_and_check(f0, f1, f2, f3);
      end else if (op == "F") begin
        flush_all();
      end else begin
        $display("Unknown opcode %0s in the golden file", op);
        end_in_failure();
      end
    end
    $fclose(fd);
    if (lookup_cnt == 0) begin
      $display("Golden file holds no lookup");
      end_in_failure();
    end

    if (dut.u_assert.fail_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d assertion failures during the run", dut.u_assert.fail_cnt);
      end_in_failure();
    end
  end

endmodule

/* test/l2tlb_golden.txt */
# L: lookup vpn exp_hit exp_ppn exp_exc (exc 0 none, 1 page fault), hex fields
# W: walker reply to the miss above ppn glob exc, A: set ASID, F: flush all
A 01
L 00010 0 a0010 0
W a0010 0 0
L 00010 1 a0010 0
L 00021 0 b0021 0
W b0021 1 0
A 02
L 00010 0 c0010 0
W c0010 0 0
L 00021 1 b0021 0
L 00102 0 d0102 0
W d0102 0 0
L 00202 0 d0202 0
W d0202 0 0
L 00302 0 d0302 0
W d0302 0 0
L 00202 1 d0202 0
L 00102 0 e0102 0
W e0102 0 0
L 00033 0 00000 1
W 00000 0 1
L 00033 0 f0033 0
W f0033 0 0
L 00033 1 f0033 0
F
L 00021 0 b1021 0
W b1021 0 0
L 00033 0 f1033 0
W f1033 0 0

/* src.f */
design/mmu_pkg.sv
design/l2tlb_pkg.sv
design/l2tlb_way_mem.sv
design/l2tlb_sched.sv
design/l2tlb_lookup.sv
design/l2tlb_mshr.sv
design/l2tlb_flush_ctrl.sv
design/l2tlb_top.sv
test/l2tlb_assert.sv
test/l2tlb_tb.sv

/* Makefile */
TOP = l2tlb_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f design/*.sv test/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
